// ==== histTb_input.txt ====
# columns: op testName a b, numbers in hex
# W addr data | R addr expected | S timestamp cycles | P 0 0 waits for done
R rst_bin0 100 0
R rst_bin63 1fc 0
R rst_status 004 0
S idle_drop 0000 5
R idle_bin0 100 0
W cfg_win 008 c8
W coarse_start 000 1
S coarse_b1 0400 3
S coarse_b2 0bff 2
S coarse_b63 fc00 1
P coarse_wait 0 0
R coarse_bin1 104 3
R coarse_bin2 108 2
R coarse_bin63 1fc 1
R coarse_bin5 114 0
R coarse_status 004 6
S done_drop 0400 4
R done_bin1 104 3
W fine_base 00c 12
W fine_start 000 3
S fine_b1a 1204 2
S fine_b1b 1207 1
S fine_b63 12fc 1
S fine_drop_hi 1304 3
S fine_drop_lo 0208 2
P fine_wait 0 0
R fine_bin1 104 3
R fine_bin63 1fc 1
R fine_bin2 108 0
R fine_status 004 2
W sat_win 008 500
W sat_start 000 1
S sat_hits 0800 44c
P sat_wait 0 0
R sat_bin2 108 3ff
R sat_status 004 6

// ==== project.f ====
+incdir+.
histPkg.sv
binAddrGen.sv
hisBuilderReg.sv
acqWindowCtrl.sv
axiLiteRegs.sv
histTop.sv
hist_chk.sv
histTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module histTb \
        -f project.f -o histSim; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/histSim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// ==== histTb.sv ====
`include "hist_defines.svh"

module histTb;

    localparam int HS_TIMEOUT = 50;    // cycles per handshake
    localparam int POLL_LIMIT = 1000;  // status reads while waiting for done

    logic                    clk;
    logic                    res;
    logic [`HIST_AXI_AW-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`HIST_AXI_DW-1:0] wdata;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`HIST_AXI_AW-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`HIST_AXI_DW-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    logic                    sampleValid;
    histPkg::tsT             sampleTs;
    logic                    done;

    int                      fd;
    int                      code;
    string                   op;
    string                   testName;
    logic [31:0]             argA;
    logic [31:0]             argB;
    logic [8*160-1:0]        lineBuf;

    histTop UUT (
        .clk, .res,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .sampleValid, .sampleTs, .done
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;  // inputs move just after the edge
    endtask

    task automatic axiWrite(input string name, input logic [31:0] addr, input logic [31:0] data);
        logic awAcc;
        logic wAcc;
        int   n;
        awaddr  = addr[`HIST_AXI_AW-1:0];
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        n = 0;
        while ((awvalid || wvalid) && n < HS_TIMEOUT) begin
            awAcc = awvalid && awready;  // readys come from registers
            wAcc  = wvalid && wready;
            nextCycle();
            if (awAcc) awvalid = 1'b0;
            if (wAcc) wvalid = 1'b0;
            n++;
        end
        assert (!awvalid && !wvalid) else
            stopRun($sformatf("%s: write address or data never accepted", name));
        n = 0;
        while (!bvalid && n < HS_TIMEOUT) begin
            nextCycle();
            n++;
        end
        assert (bvalid) else stopRun($sformatf("%s: no write response", name));
        assert (bresp === `HIST_RESP_OKAY) else
            stopRun($sformatf("mismatch %s bresp expected %h actual %h", name,
                              `HIST_RESP_OKAY, bresp));
        nextCycle();  // response taken on this edge
        bready = 1'b0;
    endtask

    task automatic axiRead(input string name, input logic [31:0] addr, output logic [31:0] data);
        logic arAcc;
        int   n;
        araddr  = addr[`HIST_AXI_AW-1:0];
        arvalid = 1'b1;
        rready  = 1'b1;
        arAcc   = 1'b0;
        n = 0;
        while (!arAcc && n < HS_TIMEOUT) begin
            arAcc = arready;
            nextCycle();
            n++;
        end
        arvalid = 1'b0;
        assert (arAcc) else stopRun($sformatf("%s: read address never accepted", name));
        n = 0;
        while (!rvalid && n < HS_TIMEOUT) begin
            nextCycle();
            n++;
        end
        assert (rvalid) else stopRun($sformatf("%s: no read data", name));
        assert (rresp === `HIST_RESP_OKAY) else
            stopRun($sformatf("mismatch %s rresp expected %h actual %h", name,
                              `HIST_RESP_OKAY, rresp));
        data = rdata;
        nextCycle();
        rready = 1'b0;
    endtask

    task automatic pollDone(input string name);
        logic [31:0] status;
        int          n;
        status = '0;
        n = 0;
        while (!status[1] && n < POLL_LIMIT) begin
            axiRead(name, `HIST_REG_STATUS, status);
            n++;
        end
        assert (status[1]) else stopRun($sformatf("%s: acquisition never finished", name));
    endtask

    task automatic driveSamples(input logic [31:0] ts, input logic [31:0] count);
        int i;
        for (i = 0; i < count; i++) begin
            sampleValid = 1'b1;
            sampleTs    = ts[`HIST_TS_W-1:0];
            nextCycle();
        end
        sampleValid = 1'b0;
    endtask

    task automatic runCommand(input string cmd, input string name,
                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] got;
        if (cmd == "W") begin
            axiWrite(name, a, b);
        end else if (cmd == "R") begin
            axiRead(name, a, got);
            assert (got === b) else
                stopRun($sformatf("mismatch %s expected %h actual %h", name, b, got));
            if (a[`HIST_AXI_AW-1:0] == `HIST_REG_STATUS) begin
                // done pin follows status bit 1
                assert (done === b[1]) else
                    stopRun($sformatf("mismatch %s done expected %b actual %b",
                                      name, b[1], done));
            end
        end else if (cmd == "S") begin
            driveSamples(a, b);
        end else if (cmd == "P") begin
            pollDone(name);
        end else begin
            stopRun($sformatf("unknown command %s in the stimulus file", cmd));
        end
    endtask

    initial begin
        res         = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        sampleValid = 1'b0;
        sampleTs    = '0;
        repeat (3) @(posedge clk);
        #1;
        res = 1'b1;
        fd = $fopen("histTb_input.txt", "r");
        assert (fd != 0) else stopRun("cannot open the stimulus file histTb_input.txt");
        code = $fscanf(fd, "%s", op);
        while (code == 1) begin
            if (op == "#") begin
                code = $fgets(lineBuf, fd);  // comment line
            end else begin
                code = $fscanf(fd, "%s %h %h", testName, argA, argB);
                assert (code == 3) else stopRun($sformatf("bad operands after command %s", op));
                runCommand(op, testName, argA, argB);
            end
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== hist_chk.sv ====
module histChk (
    input logic              clk,
    input logic              res,
    input logic              bvalid,
    input logic              bready,
    input logic              rvalid,
    input logic              rready,
    input logic              busy,
    input logic              done,
    input logic              start,
    input logic              bin0Valid,
    input histPkg::binCountT bin0Count
);

    histPkg::binCountT bin0Now;

    assign bin0Now = bin0Valid ? bin0Count : '0;  // unflagged bin reads zero

    bHold: assert property (@(posedge clk) disable iff (!res)
        bvalid && !bready |=> bvalid)
        else $error("write response dropped before bready");

    rHold: assert property (@(posedge clk) disable iff (!res)
        rvalid && !rready |=> rvalid)
        else $error("read data dropped before rready");

    busyDone: assert property (@(posedge clk) disable iff (!res)
        !(busy && done))
        else $error("busy and done high together");

    // only a clear may pull a count down
    bin0Mono: assert property (@(posedge clk) disable iff (!res)
        !start |=> bin0Now >= $past(bin0Now))
        else $error("bin 0 count went down without a clear");

endmodule

bind histTop histChk uChk (
    .clk, .res, .bvalid, .bready, .rvalid, .rready,
    .busy, .done, .start,
    .bin0Valid(uHist.binValid[0]),
    .bin0Count(uHist.counts[0])
);

// ==== histTop.sv ====
`include "hist_defines.svh"

module histTop (
    input  logic                    clk,
    input  logic                    res,
    input  logic [`HIST_AXI_AW-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`HIST_AXI_DW-1:0] wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`HIST_AXI_AW-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`HIST_AXI_DW-1:0] rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  logic                    sampleValid,
    input  histPkg::tsT             sampleTs,
    output logic                    done
);

    histPkg::histCfgT  cfg;
    histPkg::incReqT   incReq;
    histPkg::binAddrT  rdAddr;
    histPkg::binCountT rdCount;
    logic              start;  // also clears the histogram
    logic              busy;
    logic              frameToggle;

    axiLiteRegs uRegs (
        .clk, .res,
        .awaddr, .awvalid, .awready,
        .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .cfg, .start, .busy, .done, .frameToggle,
        .rdAddr, .rdCount
    );

    binAddrGen uAddr (
        .clk, .res, .sampleValid, .sampleTs, .busy, .cfg, .incReq
    );

    hisBuilderReg uHist (
        .clk, .res, .clear(start), .incReq, .rdAddr, .rdCount
    );

    acqWindowCtrl uWin (
        .clk, .res, .start, .winLen(cfg.winLen), .busy, .done, .frameToggle
    );

endmodule

// ==== axiLiteRegs.sv ====
`include "hist_defines.svh"

module axiLiteRegs (
    input  logic                    clk,
    input  logic                    res,
    // write address / data / response
    input  logic [`HIST_AXI_AW-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`HIST_AXI_DW-1:0] wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // read address / data
    input  logic [`HIST_AXI_AW-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`HIST_AXI_DW-1:0] rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // histogram side
    output histPkg::histCfgT        cfg,
    output logic                    start,
    input  logic                    busy,
    input  logic                    done,
    input  logic                    frameToggle,
    output histPkg::binAddrT        rdAddr,
    input  histPkg::binCountT       rdCount
);

    // byte offsets covered by the bin window
    localparam logic [`HIST_AXI_AW-1:0] BIN_SPAN = ((1 << `HIST_NB) - 1) << 2;

    logic                    awHeld;
    logic                    wHeld;
    logic [`HIST_AXI_AW-1:0] awAddrQ;
    logic [`HIST_AXI_DW-1:0] wDataQ;
    logic                    awFire;
    logic                    wFire;
    logic                    wrGo;
    logic [`HIST_AXI_AW-1:0] wrAddr;
    logic [`HIST_AXI_DW-1:0] wrData;

    logic                    arFire;
    logic                    binHit;
    logic [`HIST_AXI_DW-1:0] rdMux;

    // aw and w accepted independently, no new ones while a response waits
    assign awready = !awHeld && !bvalid;
    assign wready  = !wHeld && !bvalid;
    assign awFire  = awvalid && awready;
    assign wFire   = wvalid && wready;
    assign wrGo    = (awHeld || awFire) && (wHeld || wFire);  // both halves present
    assign wrAddr  = awHeld ? awAddrQ : awaddr;
    assign wrData  = wHeld ? wDataQ : wdata;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bvalid <= 1'b0;
        end else if (wrGo) begin
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bvalid <= 1'b1;
        end else begin
            if (awFire) awHeld <= 1'b1;
            if (wFire) wHeld <= 1'b1;
            if (bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awFire) awAddrQ <= awaddr;
        if (wFire) wDataQ <= wdata;
    end

    // register writes, start is a one cycle pulse
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wrGo) begin
                case (wrAddr)
                    `HIST_REG_CTRL: begin
                        start        <= wrData[0];
                        cfg.fineMode <= wrData[1];
                    end
                    `HIST_REG_WIN:  cfg.winLen   <= wrData[`HIST_WIN_W-1:0];
                    `HIST_REG_FINE: cfg.fineBase <= wrData[`HIST_FB_W-1:0];
                    default: ;  // status and bins are read only
                endcase
            end
        end
    end

    // bin index straight from the read address, memory answers combinationally
    assign rdAddr = araddr[`HIST_NB+1:2];
    assign binHit = (araddr & ~BIN_SPAN) == `HIST_REG_BIN;

    always_comb begin
        rdMux = '0;  // unmapped reads zero
        if (binHit) begin
            rdMux[`HIST_CNT_W-1:0] = rdCount;
        end else begin
            case (araddr)
                `HIST_REG_CTRL:   rdMux[1] = cfg.fineMode;
                `HIST_REG_STATUS: rdMux[2:0] = {frameToggle, done, busy};
                `HIST_REG_WIN:    rdMux[`HIST_WIN_W-1:0] = cfg.winLen;
                `HIST_REG_FINE:   rdMux[`HIST_FB_W-1:0] = cfg.fineBase;
                default: ;
            endcase
        end
    end

    assign arready = !rvalid;
    assign arFire  = arvalid && arready;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rvalid <= 1'b0;
        end else if (arFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arFire) rdata <= rdMux;
    end

    assign bresp = `HIST_RESP_OKAY;
    assign rresp = `HIST_RESP_OKAY;

endmodule

// ==== acqWindowCtrl.sv ====
module acqWindowCtrl (
    input  logic            clk,
    input  logic            res,
    input  logic            start,
    input  histPkg::winLenT winLen,
    output logic            busy,
    output logic            done,
    output logic            frameToggle
);

    histPkg::acqStateT state;
    histPkg::winLenT   remain;  // cycles left in RUN

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= histPkg::IDLE;
            remain      <= '0;
            frameToggle <= 1'b0;
        end else if (start) begin
            // start from any state restarts the window
            remain <= winLen;
            if (winLen == '0) begin
                state       <= histPkg::DONE;
                frameToggle <= ~frameToggle;
            end else begin
                state <= histPkg::RUN;
            end
        end else begin
            case (state)
                histPkg::RUN: begin
                    if (remain == histPkg::winLenT'(1)) begin
                        state       <= histPkg::DONE;  // last busy cycle
                        remain      <= '0;
                        frameToggle <= ~frameToggle;
                    end else begin
                        remain <= remain - 1'b1;
                    end
                end
                histPkg::IDLE,
                histPkg::DONE: begin
                    state <= state;  // wait for the next start
                end
                default: begin
                    state <= histPkg::IDLE;
                end
            endcase
        end
    end

    assign busy = (state == histPkg::RUN);
    assign done = (state == histPkg::DONE);

endmodule

// ==== hisBuilderReg.sv ====
`include "hist_defines.svh"

module hisBuilderReg (
    input  logic              clk,
    input  logic              res,
    input  logic              clear,
    input  histPkg::incReqT   incReq,
    input  histPkg::binAddrT  rdAddr,
    output histPkg::binCountT rdCount
);

    localparam int NBINS = 1 << `HIST_NB;
    localparam histPkg::binCountT CNT_MAX = {`HIST_CNT_W{1'b1}};

    histPkg::binCountT counts [NBINS];
    logic [NBINS-1:0]  binValid;  // one flag per bin, cleared all at once

    histPkg::binCountT curCount;
    histPkg::binCountT nextCount;
    logic              doInc;

    // a cleared bin behaves as zero, so a first hit writes 1
    assign curCount = binValid[incReq.bin] ? counts[incReq.bin] : '0;

    always_comb begin
        if (curCount == CNT_MAX) begin
            nextCount = CNT_MAX;  // saturate
        end else begin
            nextCount = curCount + 1'b1;
        end
    end

    // clear wins over an increment in the same cycle
    assign doInc = incReq.valid && !clear;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid <= '0;
        end else if (clear) begin
            binValid <= '0;
        end else if (incReq.valid) begin
            binValid[incReq.bin] <= 1'b1;
        end
    end

    // count storage, read-modify-write in one cycle so
    // back to back hits on one bin all land
    always_ff @(posedge clk) begin
        if (doInc) begin
            counts[incReq.bin] <= nextCount;
        end
    end

    // read port for the bus
    always_comb begin
        if (binValid[rdAddr]) begin
            rdCount = counts[rdAddr];
        end else begin
            rdCount = '0;
        end
    end

endmodule

// ==== binAddrGen.sv ====
`include "hist_defines.svh"

module binAddrGen (
    input  logic             clk,
    input  logic             res,
    input  logic             sampleValid,
    input  histPkg::tsT      sampleTs,
    input  logic             busy,
    input  histPkg::histCfgT cfg,
    output histPkg::incReqT  incReq
);

    histPkg::binAddrT coarseBin;
    histPkg::binAddrT fineBin;
    histPkg::binAddrT binNext;
    logic             inFineWin;
    logic             keep;

    logic             validQ;
    histPkg::binAddrT binQ;

    // coarse takes the msbs, fine takes the field above the dropped lsbs
    assign coarseBin = sampleTs[`HIST_TS_W-1 -: `HIST_NB];
    assign fineBin   = sampleTs[`HIST_FINE_SHIFT +: `HIST_NB];
    assign inFineWin = (sampleTs[`HIST_TS_W-1 -: `HIST_FB_W] == cfg.fineBase);

    always_comb begin
        if (cfg.fineMode) begin
            binNext = fineBin;
            keep    = inFineWin;  // outside the fine window gets dropped
        end else begin
            binNext = coarseBin;
            keep    = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            validQ <= 1'b0;
        end else begin
            validQ <= sampleValid && busy && keep;  // only count inside the window
        end
    end

    // address payload, qualified by validQ
    always_ff @(posedge clk) begin
        binQ <= binNext;
    end

    assign incReq.valid = validQ;
    assign incReq.bin   = binQ;

endmodule

// ==== histPkg.sv ====
`include "hist_defines.svh"

package histPkg;

    typedef logic [`HIST_NB-1:0]    binAddrT;
    typedef logic [`HIST_CNT_W-1:0] binCountT;
    typedef logic [`HIST_TS_W-1:0]  tsT;
    typedef logic [`HIST_WIN_W-1:0] winLenT;
    typedef logic [`HIST_FB_W-1:0]  fineBaseT;

    // one increment per clock into the count memory
    typedef struct packed {
        logic    valid;
        binAddrT bin;
    } incReqT;

    // software programmed configuration
    typedef struct packed {
        logic     fineMode;
        fineBaseT fineBase;  // compared against the top ts bits
        winLenT   winLen;    // window length in clocks
    } histCfgT;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } acqStateT;

endpackage

// ==== hist_defines.svh ====
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// histogram geometry
`define HIST_NB          6      // bin address bits, 64 bins
`define HIST_CNT_W       10     // saturates at 1023
`define HIST_TS_W        16
`define HIST_FINE_SHIFT  2      // lsbs dropped in fine mode
`define HIST_FB_W        8      // fine base, ts bits above the fine field
`define HIST_WIN_W       20

// bus widths
`define HIST_AXI_AW      12
`define HIST_AXI_DW      32

// register map
`define HIST_REG_CTRL    12'h000  // bit0 start, bit1 fine mode
`define HIST_REG_STATUS  12'h004  // bit0 busy, bit1 done, bit2 frame toggle
`define HIST_REG_WIN     12'h008
`define HIST_REG_FINE    12'h00C
`define HIST_REG_BIN     12'h100  // bin n at base + 4n

// okay response on both channels
`define HIST_RESP_OKAY   2'b00

`endif
